/* common/usi_config.svh */
`ifndef USI_CONFIG_SVH
`define USI_CONFIG_SVH

// Block map codes
`define GPIO_MAP        8'h01
`define PWM_MAP         8'h02

// GPIO register offsets
`define GPIO_LED_OFS    8'd0
`define GPIO_IN_OFS     8'd1

// PWM register offsets
`define PWM_PERIOD_OFS  8'd0
`define PWM_DUTY_OFS    8'd1
`define PWM_ENABLE_OFS  8'd2
`define PWM_COUNT_OFS   8'd3

// Defaults written at boot
`define BOOT_PERIOD     32'd16
`define BOOT_DUTY       32'd4
`define BOOT_LED        32'h15

// Port and counter widths
`define PWM_WIDTH       16
`define LED_WIDTH       5
`define GPIO_IN_WIDTH   4

`endif

/* common/usiPkg.sv */
//--------------------------------------------------------------------------
// USI bus types
//--------------------------------------------------------------------------
package usiPkg;

	// Bus address, upper byte is block code, lower byte is register offset
	typedef logic [15:0] usiAdrsT;

	// Bus data word
	typedef logic [31:0] usiDataT;

	// Block map code
	typedef logic [7:0] blockCodeT;

	// Boot sequencer states
	typedef enum logic [2:0]
	{
		BootIdle,
		BootPeriod,
		BootDuty,
		BootLed,
		BootDone
	} bootStateT;

	// Block code from the address upper byte
	function automatic blockCodeT blockOf(input usiAdrsT adrs);
		return adrs[15:8];
	endfunction

	// Register offset from the address lower byte
	function automatic logic [7:0] ofsOf(input usiAdrsT adrs);
		return adrs[7:0];
	endfunction

endpackage

/* pwm/pwmTimer.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module pwmTimer
(
	input  logic                   sysClk,
	input  logic                   rstN,
	input  logic [`PWM_WIDTH-1:0]  period,
	input  logic                   enable,
	output logic [`PWM_WIDTH-1:0]  count,
	output logic                   periodEnd
);

	logic run;
	logic last;

	// Zero period counts as stopped
	assign run  = enable && (period != '0);

	// Also catches a count left above a shrunk period
	assign last = (count >= period - 1'b1);

	//--------------------------------------------------------------------------
	// Period counter
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
		end
		else if (!run)
		begin
			count <= '0;
		end
		else if (last)
		begin
			// Reload
			count <= '0;
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	// Pulse on the final count of each period
	assign periodEnd = run && last;

endmodule

/* pwm/pwmBlock.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module pwmBlock
(
	input  logic             sysClk,
	input  logic             rstN,
	input  usiPkg::usiDataT  sWd,
	input  usiPkg::usiAdrsT  sAdrs,
	input  logic             sWCke,
	input  logic             sREn,
	output usiPkg::usiDataT  sRd,
	output logic             sREd,
	output logic             pwmOut
);

	import usiPkg::*;

	logic                  hit;
	logic [`PWM_WIDTH-1:0] period;
	logic [`PWM_WIDTH-1:0] duty;
	logic                  enable;
	logic [`PWM_WIDTH-1:0] count;
	logic                  periodEnd;
	usiDataT               doneCnt;
	usiDataT               rdData;

	assign hit = (blockOf(sAdrs) == `PWM_MAP);

	//--------------------------------------------------------------------------
	// Register file
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			period  <= '0;
			duty    <= '0;
			enable  <= 1'b0;
			doneCnt <= '0;
			sREd    <= 1'b0;
		end
		else
		begin
			if (sWCke && hit)
			begin
				case (ofsOf(sAdrs))
					`PWM_PERIOD_OFS: period <= sWd[`PWM_WIDTH-1:0];
					`PWM_DUTY_OFS:   duty   <= sWd[`PWM_WIDTH-1:0];
					`PWM_ENABLE_OFS: enable <= sWd[0];
					default:         enable <= enable;
				endcase
			end
			// Completed periods, wraps naturally
			if (periodEnd)
			begin
				doneCnt <= doneCnt + 1'b1;
			end
			sREd <= sREn && hit;
		end
	end

	// Read data latch
	always_ff @(posedge sysClk)
	begin
		if (sREn && hit)
		begin
			case (ofsOf(sAdrs))
				`PWM_PERIOD_OFS: rdData <= usiDataT'(period);
				`PWM_DUTY_OFS:   rdData <= usiDataT'(duty);
				`PWM_ENABLE_OFS: rdData <= usiDataT'(enable);
				`PWM_COUNT_OFS:  rdData <= doneCnt;
				default:         rdData <= '0;
			endcase
		end
	end

	assign sRd = sREd ? rdData : '0;

	//--------------------------------------------------------------------------
	// Timer and duty compare
	//--------------------------------------------------------------------------
	pwmTimer pwmTimer_i
	(
		.sysClk    (sysClk),
		.rstN      (rstN),
		.period    (period),
		.enable    (enable),
		.count     (count),
		.periodEnd (periodEnd)
	);

	// High for the first duty counts of each period
	assign pwmOut = enable && (period != '0) && (count < duty);

endmodule

/* source/gpioBlock.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module gpioBlock
(
	input  logic                       sysClk,
	input  logic                       rstN,
	input  usiPkg::usiDataT            sWd,
	input  usiPkg::usiAdrsT            sAdrs,
	input  logic                       sWCke,
	input  logic                       sREn,
	output usiPkg::usiDataT            sRd,
	output logic                       sREd,
	input  logic [`GPIO_IN_WIDTH-1:0]  gpioIn,
	output logic [`LED_WIDTH-1:0]      led
);

	import usiPkg::*;

	logic                      hit;
	logic [`GPIO_IN_WIDTH-1:0] inMeta;
	logic [`GPIO_IN_WIDTH-1:0] inSync;
	usiDataT                   rdData;

	// Addressed by block code only
	assign hit = (blockOf(sAdrs) == `GPIO_MAP);

	//--------------------------------------------------------------------------
	// LED register and input sync
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			led    <= '0;
			inMeta <= '0;
			inSync <= '0;
		end
		else
		begin
			// Two flops for async pins
			inMeta <= gpioIn;
			inSync <= inMeta;
			if (sWCke && hit && (ofsOf(sAdrs) == `GPIO_LED_OFS))
			begin
				led <= sWd[`LED_WIDTH-1:0];
			end
		end
	end

	//--------------------------------------------------------------------------
	// Read response
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sREd <= 1'b0;
		end
		else
		begin
			sREd <= sREn && hit;
		end
	end

	// Read data latch
	always_ff @(posedge sysClk)
	begin
		if (sREn && hit)
		begin
			case (ofsOf(sAdrs))
				`GPIO_LED_OFS: rdData <= usiDataT'(led);
				`GPIO_IN_OFS:  rdData <= usiDataT'(inSync);
				default:       rdData <= '0;
			endcase
		end
	end

	// Zero when idle for the fabric OR merge
	assign sRd = sREd ? rdData : '0;

endmodule

/* source/bootSequencer.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module bootSequencer
(
	input  logic             sysClk,
	input  logic             rstN,
	output usiPkg::usiDataT  wd,
	output usiPkg::usiAdrsT  adrs,
	output logic             wEd,
	output logic             done
);

	import usiPkg::*;

	bootStateT state;
	bootStateT nextState;

	//--------------------------------------------------------------------------
	// State register
	//--------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= BootIdle;
		end
		else
		begin
			state <= nextState;
		end
	end

	// One write per state, then park in BootDone
	always_comb
	begin
		unique case (state)
			BootIdle:   nextState = BootPeriod;
			BootPeriod: nextState = BootDuty;
			BootDuty:   nextState = BootLed;
			BootLed:    nextState = BootDone;
			default:    nextState = BootDone;
		endcase
	end

	//--------------------------------------------------------------------------
	// Write strobes decoded from state
	//--------------------------------------------------------------------------
	always_comb
	begin
		wd   = '0;
		adrs = '0;
		wEd  = 1'b0;
		unique case (state)
			BootPeriod:
			begin
				// Backlight period
				wd   = `BOOT_PERIOD;
				adrs = {`PWM_MAP, `PWM_PERIOD_OFS};
				wEd  = 1'b1;
			end
			BootDuty:
			begin
				// Backlight duty, enable left off for the host
				wd   = `BOOT_DUTY;
				adrs = {`PWM_MAP, `PWM_DUTY_OFS};
				wEd  = 1'b1;
			end
			BootLed:
			begin
				// Power-on LED pattern
				wd   = `BOOT_LED;
				adrs = {`GPIO_MAP, `GPIO_LED_OFS};
				wEd  = 1'b1;
			end
			default:
			begin
				wEd = 1'b0;
			end
		endcase
	end

	// Bus handed to host from here on
	assign done = (state == BootDone);

endmodule

/* source/usiFabric.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module usiFabric
(
	input  logic             sysClk,
	input  logic             rstN,
	// Boot master
	input  usiPkg::usiDataT  bootWd,
	input  usiPkg::usiAdrsT  bootAdrs,
	input  logic             bootWEd,
	input  logic             bootDone,
	// Host master
	input  usiPkg::usiDataT  hostWd,
	input  usiPkg::usiAdrsT  hostAdrs,
	input  logic             hostWEd,
	input  logic             hostREn,
	output usiPkg::usiDataT  hostRd,
	output logic             hostREd,
	// Slave broadcast
	output usiPkg::usiDataT  sWd,
	output usiPkg::usiAdrsT  sAdrs,
	output logic             sWCke,
	output logic             sREn,
	// Slave returns
	input  usiPkg::usiDataT  gpioRd,
	input  logic             gpioREd,
	input  usiPkg::usiDataT  pwmRd,
	input  logic             pwmREd
);

	import usiPkg::*;

	blockCodeT reqBlock;
	logic      mapped;
	logic      missREd;

	//--------------------------------------------------------------------------
	// Master select
	//--------------------------------------------------------------------------
	// Boot sequencer holds the bus until done, like a monopoly select
	always_comb
	begin
		if (bootDone)
		begin
			sWd   = hostWd;
			sAdrs = hostAdrs;
			sWCke = hostWEd;
			// Reads only come from the host
			sREn  = hostREn;
		end
		else
		begin
			sWd   = bootWd;
			sAdrs = bootAdrs;
			sWCke = bootWEd;
			// Host strobes dropped during boot
			sREn  = 1'b0;
		end
	end

	//--------------------------------------------------------------------------
	// Block decode
	//--------------------------------------------------------------------------
	assign reqBlock = blockOf(sAdrs);
	assign mapped   = (reqBlock == `GPIO_MAP) || (reqBlock == `PWM_MAP);

	// Unmapped read still gets a valid one cycle later
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			missREd <= 1'b0;
		end
		else
		begin
			missREd <= sREn && !mapped;
		end
	end

	//--------------------------------------------------------------------------
	// Read return
	//--------------------------------------------------------------------------
	// Idle slaves drive zero, so OR merge is enough
	assign hostRd  = gpioRd | pwmRd;
	assign hostREd = gpioREd | pwmREd | missREd;

endmodule

/* source/processer.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module processer
(
	input  logic                       sysClk,
	input  logic                       rstN,
	// Host port
	input  usiPkg::usiDataT            hostWd,
	input  usiPkg::usiAdrsT            hostAdrs,
	input  logic                       hostWEd,
	input  logic                       hostREn,
	output usiPkg::usiDataT            hostRd,
	output logic                       hostREd,
	output logic                       bootDone,
	// External pins
	input  logic [`GPIO_IN_WIDTH-1:0]  gpioIn,
	output logic [`LED_WIDTH-1:0]      led,
	output logic                       pwmOut
);

	import usiPkg::*;

	//--------------------------------------------------------------------------
	// Boot master
	//--------------------------------------------------------------------------
	usiDataT bootWd;
	usiAdrsT bootAdrs;
	logic    bootWEd;

	bootSequencer bootSequencer_i
	(
		.sysClk    (sysClk),
		.rstN      (rstN),
		.wd        (bootWd),
		.adrs      (bootAdrs),
		.wEd       (bootWEd),
		.done      (bootDone)
	);

	//--------------------------------------------------------------------------
	// Bus fabric
	//--------------------------------------------------------------------------
	// Broadcast to slaves
	usiDataT sWd;
	usiAdrsT sAdrs;
	logic    sWCke;
	logic    sREn;
	// Slave returns
	usiDataT gpioRd;
	logic    gpioREd;
	usiDataT pwmRd;
	logic    pwmREd;

	usiFabric usiFabric_i
	(
		.sysClk    (sysClk),
		.rstN      (rstN),
		.bootWd    (bootWd),
		.bootAdrs  (bootAdrs),
		.bootWEd   (bootWEd),
		.bootDone  (bootDone),
		.hostWd    (hostWd),
		.hostAdrs  (hostAdrs),
		.hostWEd   (hostWEd),
		.hostREn   (hostREn),
		.hostRd    (hostRd),
		.hostREd   (hostREd),
		.sWd       (sWd),
		.sAdrs     (sAdrs),
		.sWCke     (sWCke),
		.sREn      (sREn),
		.gpioRd    (gpioRd),
		.gpioREd   (gpioREd),
		.pwmRd     (pwmRd),
		.pwmREd    (pwmREd)
	);

	//--------------------------------------------------------------------------
	// Peripherals
	//--------------------------------------------------------------------------
	gpioBlock gpioBlock_i
	(
		.sysClk    (sysClk),
		.rstN      (rstN),
		.sWd       (sWd),
		.sAdrs     (sAdrs),
		.sWCke     (sWCke),
		.sREn      (sREn),
		.sRd       (gpioRd),
		.sREd      (gpioREd),
		.gpioIn    (gpioIn),
		.led       (led)
	);

	// Backlight PWM
	pwmBlock pwmBlock_i
	(
		.sysClk    (sysClk),
		.rstN      (rstN),
		.sWd       (sWd),
		.sAdrs     (sAdrs),
		.sWCke     (sWCke),
		.sREn      (sREn),
		.sRd       (pwmRd),
		.sREd      (pwmREd),
		.pwmOut    (pwmOut)
	);

endmodule

/* verification/usiFabric_props.sv */
`timescale 1ns/1ps

module usiFabric_props
(
	input logic sysClk,
	input logic rstN,
	input logic bootDone,
	input logic bootWEd,
	input logic hostWEd,
	input logic hostREn,
	input logic hostREd,
	input logic sWCke,
	input logic sREn
);

	//--------------------------------------------------------------------------
	// Read timing
	//--------------------------------------------------------------------------
	// Accepted host read answered in the next cycle
	assert property (@(posedge sysClk) disable iff (!rstN)
		(hostREn && bootDone) |=> hostREd)
		else $error("hostREd missing one cycle after hostREn");

	// No read valid without a read one cycle earlier
	assert property (@(posedge sysClk) disable iff (!rstN)
		hostREd |-> $past(hostREn && bootDone))
		else $error("hostREd without a preceding hostREn");

	//--------------------------------------------------------------------------
	// Ownership and strobe exclusion
	//--------------------------------------------------------------------------
	// Boot master owns the write strobe until done
	assert property (@(posedge sysClk) disable iff (!rstN)
		!bootDone |-> (sWCke == bootWEd))
		else $error("Host write reached the slaves during boot");

	assert property (@(posedge sysClk) disable iff (!rstN)
		!(hostWEd && hostREn) && !(sWCke && sREn))
		else $error("Write and read strobes high together");

endmodule

bind usiFabric usiFabric_props usiFabric_props_i
(
	.sysClk   (sysClk),
	.rstN     (rstN),
	.bootDone (bootDone),
	.bootWEd  (bootWEd),
	.hostWEd  (hostWEd),
	.hostREn  (hostREn),
	.hostREd  (hostREd),
	.sWCke    (sWCke),
	.sREn     (sREn)
);

/* verification/processerTb.sv */
`timescale 1ns/1ps
`include "usi_config.svh"

module processerTb;

	import usiPkg::*;

	localparam int readTimeout = 8;
	localparam int bootTimeout = 20;
	localparam usiAdrsT ledAdrs    = {`GPIO_MAP, `GPIO_LED_OFS};
	localparam usiAdrsT inAdrs     = {`GPIO_MAP, `GPIO_IN_OFS};
	localparam usiAdrsT periodAdrs = {`PWM_MAP, `PWM_PERIOD_OFS};
	localparam usiAdrsT dutyAdrs   = {`PWM_MAP, `PWM_DUTY_OFS};
	localparam usiAdrsT enableAdrs = {`PWM_MAP, `PWM_ENABLE_OFS};
	localparam usiAdrsT countAdrs  = {`PWM_MAP, `PWM_COUNT_OFS};

	logic                      sysClk;
	logic                      rstN;
	usiDataT                   hostWd;
	usiAdrsT                   hostAdrs;
	logic                      hostWEd;
	logic                      hostREn;
	usiDataT                   hostRd;
	logic                      hostREd;
	logic                      bootDone;
	logic [`GPIO_IN_WIDTH-1:0] gpioIn;
	logic [`LED_WIDTH-1:0]     led;
	logic                      pwmOut;

	// Register model
	logic [`LED_WIDTH-1:0]     ledModel;
	logic [`PWM_WIDTH-1:0]     periodModel;
	logic [`PWM_WIDTH-1:0]     dutyModel;
	logic                      enableModel;
	logic [`GPIO_IN_WIDTH-1:0] gpioModel;

	// Pending reads in issue order
	usiDataT expQ[$];
	bit      cmpQ[$];
	usiDataT expData;
	bit      doCompare;
	logic    lastREd;

	integer  seed;
	int      errorCount;
	int      checkCount;
	int      waitCnt;
	int      pLen;
	int      dLen;
	int      nPeriods;
	int      highCount;
	usiAdrsT adrs;
	usiDataT data;
	usiDataT cnt0;
	usiDataT cnt1;

	processer dut_i
	(
		.sysClk   (sysClk),
		.rstN     (rstN),
		.hostWd   (hostWd),
		.hostAdrs (hostAdrs),
		.hostWEd  (hostWEd),
		.hostREn  (hostREn),
		.hostRd   (hostRd),
		.hostREd  (hostREd),
		.bootDone (bootDone),
		.gpioIn   (gpioIn),
		.led      (led),
		.pwmOut   (pwmOut)
	);

	initial
	begin
		sysClk = 1'b0;
		forever #20 sysClk = ~sysClk;
	end

	//--------------------------------------------------------------------------
	// Reference model
	//--------------------------------------------------------------------------
	function automatic int randomBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Accepted host write truncated to the register field widths
	function automatic void modelWrite(input usiAdrsT a, input usiDataT d);
		if (a == ledAdrs)
			ledModel = d[`LED_WIDTH-1:0];
		else if (a == periodAdrs)
			periodModel = d[`PWM_WIDTH-1:0];
		else if (a == dutyAdrs)
			dutyModel = d[`PWM_WIDTH-1:0];
		else if (a == enableAdrs)
			enableModel = d[0];
	endfunction

	// Expected read data with zero for unmapped blocks and offsets
	function automatic usiDataT expectedRead(input usiAdrsT a);
		usiDataT value;
		value = '0;
		if (a == ledAdrs)
			value = usiDataT'(ledModel);
		else if (a == inAdrs)
			value = usiDataT'(gpioModel);
		else if (a == periodAdrs)
			value = usiDataT'(periodModel);
		else if (a == dutyAdrs)
			value = usiDataT'(dutyModel);
		else if (a == enableAdrs)
			value = usiDataT'(enableModel);
		return value;
	endfunction

	task automatic checkValue(input string name, input usiDataT got, input usiDataT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	//--------------------------------------------------------------------------
	// Host port driver
	//--------------------------------------------------------------------------
	task automatic hostWrite(input usiAdrsT a, input usiDataT d);
		@(posedge sysClk);
		hostAdrs <= a;
		hostWd   <= d;
		hostWEd  <= 1'b1;
		@(posedge sysClk);
		hostWEd  <= 1'b0;
		modelWrite(a, d);
	endtask

	// Count register reads are not compared against the model
	task automatic hostRead(input usiAdrsT a, input bit compare, output usiDataT d);
		expQ.push_back(expectedRead(a));
		cmpQ.push_back(compare);
		@(posedge sysClk);
		hostAdrs <= a;
		hostREn  <= 1'b1;
		@(posedge sysClk);
		hostREn  <= 1'b0;
		waitCnt = 0;
		@(negedge sysClk);
		while (!hostREd && waitCnt < readTimeout)
		begin
			@(negedge sysClk);
			waitCnt++;
		end
		d = hostRd;
		if (!hostREd)
		begin
			errorCount++;
			$display("No read valid for address 0x%h within %0d cycles", a, readTimeout);
			// Drop the entry nobody answered
			void'(expQ.pop_back());
			void'(cmpQ.pop_back());
		end
	endtask

	//--------------------------------------------------------------------------
	// Read data checker
	//--------------------------------------------------------------------------
	always @(negedge sysClk)
	begin
		if (rstN && hostREd && !lastREd)
		begin
			if (expQ.size() == 0)
			begin
				errorCount++;
				$display("Read valid seen with no read pending");
			end
			else
			begin
				expData   = expQ.pop_front();
				doCompare = cmpQ.pop_front();
				if (doCompare)
					checkValue("hostRd", hostRd, expData);
			end
		end
		lastREd = hostREd;
	end

	//--------------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------------
	initial
	begin
		seed = 32'ha462;
		errorCount = 0;
		checkCount = 0;
		lastREd = 1'b0;
		rstN = 1'b0;
		hostWd = '0;
		hostAdrs = '0;
		hostWEd = 1'b0;
		hostREn = 1'b0;
		gpioIn = '0;
		gpioModel = '0;
		// Boot defaults with enable off
		ledModel = `BOOT_LED;
		periodModel = `BOOT_PERIOD;
		dutyModel = `BOOT_DUTY;
		enableModel = 1'b0;
		repeat (3) @(posedge sysClk);

		// Host writes during boot are dropped
		rstN <= 1'b1;
		hostAdrs <= ledAdrs;
		hostWd <= 32'h0a;
		hostWEd <= 1'b1;
		@(posedge sysClk);
		hostAdrs <= enableAdrs;
		hostWd <= 32'h1;
		@(posedge sysClk);
		hostWEd <= 1'b0;
		// LED still at its reset value before the boot LED write
		@(negedge sysClk);
		checkValue("led", usiDataT'(led), 32'h0);

		waitCnt = 0;
		while (!bootDone && waitCnt < bootTimeout)
		begin
			@(negedge sysClk);
			waitCnt++;
		end
		if (!bootDone)
		begin
			errorCount++;
			$display("bootDone did not rise within %0d cycles", bootTimeout);
		end

		// Boot defaults
		hostRead(periodAdrs, 1'b1, data);
		hostRead(dutyAdrs, 1'b1, data);
		hostRead(ledAdrs, 1'b1, data);
		hostRead(enableAdrs, 1'b1, data);
		checkValue("led", usiDataT'(led), `BOOT_LED);
		checkValue("pwmOut", usiDataT'(pwmOut), 32'h0);

		// Random write and read-back
		repeat (24)
		begin
			case (randomBelow(4))
				0: adrs = ledAdrs;
				1: adrs = periodAdrs;
				2: adrs = dutyAdrs;
				default: adrs = enableAdrs;
			endcase
			data = $random(seed);
			hostWrite(adrs, data);
			@(negedge sysClk);
			checkValue("led", usiDataT'(led), usiDataT'(ledModel));
			hostRead(adrs, 1'b1, data);
		end

		// GPIO inputs through the synchronizer
		repeat (8)
		begin
			@(posedge sysClk);
			gpioModel = 4'(randomBelow(16));
			gpioIn <= gpioModel;
			repeat (3) @(posedge sysClk);
			hostRead(inAdrs, 1'b1, data);
		end

		// PWM duty over whole periods
		pLen = 2 + randomBelow(19);
		dLen = randomBelow(pLen + 1);
		nPeriods = 3 + randomBelow(3);
		hostWrite(enableAdrs, 32'h0);
		hostWrite(periodAdrs, usiDataT'(pLen));
		hostWrite(dutyAdrs, usiDataT'(dLen));
		hostWrite(enableAdrs, 32'h1);
		repeat (2 * pLen + 2) @(posedge sysClk);
		highCount = 0;
		repeat (nPeriods * pLen)
		begin
			@(negedge sysClk);
			if (pwmOut)
				highCount++;
		end
		checkValue("pwmOut high cycles", usiDataT'(highCount), usiDataT'(nPeriods * dLen));

		// Completed periods over two reads exactly N*P cycles apart
		nPeriods = 2 + randomBelow(4);
		hostRead(countAdrs, 1'b0, cnt0);
		repeat (nPeriods * pLen - 2) @(posedge sysClk);
		hostRead(countAdrs, 1'b0, cnt1);
		checkValue("period count delta", cnt1 - cnt0, usiDataT'(nPeriods));

		// Unmapped block codes read zero
		hostRead({8'h00, 8'h00}, 1'b1, data);
		repeat (6)
		begin
			adrs = {8'(randomBelow(253) + 3), 8'(randomBelow(256))};
			hostRead(adrs, 1'b1, data);
		end

		repeat (2) @(negedge sysClk);
		if (expQ.size() != 0)
		begin
			errorCount++;
			$display("Reads still pending at the end of the run");
		end
		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+common
common/usiPkg.sv
pwm/pwmTimer.sv
pwm/pwmBlock.sv
source/gpioBlock.sv
source/bootSequencer.sv
source/usiFabric.sv
source/processer.sv
verification/usiFabric_props.sv
verification/processerTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the processer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module processerTb \
	-o processerTb

output=$(./obj_dir/processerTb)
echo "$output"

if grep -qx "ALL CHECKS PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi
